// ==== logic/cpu_settings.svh ====
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

////////////////////////////////////////
// sizes
////////////////////////////////////////

// register and data word width
`define CPU_DATA_WIDTH 16
// instruction word width, 2-bit prefix plus 16 bits
`define CPU_INST_WIDTH 18
`define CPU_REG_COUNT 16
`define CPU_MEM_DEPTH 256

////////////////////////////////////////
// primary opcodes, inst[15:12]
////////////////////////////////////////

`define OP_RTYPE  4'b0000
`define OP_ADDI   4'b0101
`define OP_ADDUI  4'b0110
`define OP_ADDCI  4'b0111
// takes the old SUBCI slot
`define OP_ADDCUI 4'b1010
`define OP_SUBI   4'b1001
`define OP_CMPI   4'b1011
// takes the old MULI slot
`define OP_CMPUI  4'b1110
`define OP_MOVI   4'b1101
`define OP_LUI    4'b1111
`define OP_SHIFT  4'b1000
`define OP_MEM    4'b0100
`define OP_GSTOR  4'b1100

////////////////////////////////////////
// secondary codes, inst[7:4]
////////////////////////////////////////

// register forms under OP_RTYPE
`define EXT_ADD   4'b0101
`define EXT_ADDU  4'b0110
`define EXT_ADDC  4'b0111
`define EXT_ADDCU 4'b0100
`define EXT_SUB   4'b1001
`define EXT_CMP   4'b1011
`define EXT_AND   4'b0001
`define EXT_OR    4'b0010
`define EXT_XOR   4'b0011
`define EXT_NOT   4'b1111
`define EXT_MOV   4'b1101
// shift forms under OP_SHIFT
`define EXT_LSH   4'b0100
`define EXT_LSHI  4'b0000
`define EXT_RSH   4'b1100
`define EXT_RSHI  4'b0001
`define EXT_ALSH  4'b0101
`define EXT_ARSH  4'b1101
// memory forms under OP_MEM
`define EXT_LOAD  4'b0000
`define EXT_STOR  4'b0100
// conditional jumps, also under OP_MEM
`define EXT_JCOND 4'b1100

`endif

// ==== logic/cpuPkg.sv ====
`include "cpu_settings.svh"

package cpuPkg;

	////////////////////////////////////////
	// instruction word
	////////////////////////////////////////

	// register form: op rDest, rSrc with a secondary code
	typedef struct packed {
		logic [1:0] prefix;
		logic [3:0] opcode;
		logic [3:0] rDest;
		logic [3:0] ext;
		logic [3:0] rSrc;
	} regForm_t;

	// immediate form: op rDest, imm8
	typedef struct packed {
		logic [1:0] prefix;
		logic [3:0] opcode;
		logic [3:0] rDest;
		logic [7:0] imm8;
	} immForm_t;

	// long form, prefix 2'b11 carries a full data word
	typedef struct packed {
		logic [1:0] prefix;
		logic [`CPU_DATA_WIDTH-1:0] imm16;
	} longForm_t;

	// same 18 bits, three readings
	typedef union packed {
		regForm_t r;
		immForm_t i;
		longForm_t l;
	} instWord_t;

	////////////////////////////////////////
	// decoder output
	////////////////////////////////////////

	typedef struct packed {
		logic [7:0] op;                         // primary then secondary code
		logic [`CPU_DATA_WIDTH-1:0] imm;        // extended immediate
		logic selectImm;                        // imm replaces operand b
		logic selectResult;                     // write-back from memory
		logic memWrite;
		logic [$clog2(`CPU_REG_COUNT)-1:0] memAddr;
		logic [$clog2(`CPU_REG_COUNT)-1:0] readRegA;
		logic [$clog2(`CPU_REG_COUNT)-1:0] readRegB;
		logic [$clog2(`CPU_REG_COUNT)-1:0] loadReg;
	} decoded_t;

	// processor status flags
	typedef struct packed {
		logic c;  // carry or borrow
		logic f;  // signed overflow
		logic z;  // equal
		logic l;  // unsigned less-than
		logic n;  // signed less-than
	} flags_t;

endpackage

// ==== logic/decoder.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module decoder (
	input cpuPkg::instWord_t inst,
	output cpuPkg::decoded_t dec
);

	// OR of a register with itself, the encoding every unused form falls back to
	localparam logic [7:0] noOpCode = {`OP_RTYPE, `EXT_OR};

	always_comb begin
		// defaults: rDest is source a and destination, rSrc is source b
		dec = '0;
		dec.readRegA = inst.r.rDest;
		dec.readRegB = inst.r.rSrc;
		dec.loadReg = inst.r.rDest;
		dec.memAddr = 4'b1010;
		if (inst.r.prefix == 2'b00) begin
			case (inst.r.opcode)
				`OP_RTYPE: begin
					case (inst.r.ext)
						`EXT_ADD, `EXT_ADDU, `EXT_ADDC, `EXT_ADDCU, `EXT_SUB, `EXT_CMP,
						`EXT_AND, `EXT_OR, `EXT_XOR, `EXT_NOT: begin
							dec.op = {`OP_RTYPE, inst.r.ext};
						end
						`EXT_MOV: begin
							// both operand ports look at rSrc
							dec.op = {`OP_RTYPE, `EXT_MOV};
							dec.readRegA = inst.r.rSrc;
						end
						default: begin
							dec.op = noOpCode;
							dec.readRegB = inst.r.rDest;
						end
					endcase
				end
				// signed immediates, sign extended
				`OP_ADDI, `OP_ADDCI, `OP_SUBI, `OP_CMPI: begin
					dec.op = {inst.i.opcode, 4'b0000};
					dec.selectImm = 1'b1;
					dec.imm = {{8{inst.i.imm8[7]}}, inst.i.imm8};
				end
				// unsigned immediates, zero extended
				`OP_ADDUI, `OP_ADDCUI, `OP_CMPUI, `OP_MOVI: begin
					dec.op = {inst.i.opcode, 4'b0000};
					dec.selectImm = 1'b1;
					dec.imm = {8'h00, inst.i.imm8};
				end
				`OP_LUI: begin
					// imm8 lands in the upper byte
					dec.op = {`OP_LUI, 4'b0000};
					dec.selectImm = 1'b1;
					dec.imm = {inst.i.imm8, 8'h00};
				end
				`OP_SHIFT: begin
					case (inst.r.ext)
						`EXT_LSH, `EXT_RSH, `EXT_ALSH, `EXT_ARSH: begin
							dec.op = {`OP_SHIFT, inst.r.ext};
						end
						`EXT_LSHI, `EXT_RSHI: begin
							// shift count sits in the rSrc field, unsigned
							dec.op = {`OP_SHIFT, inst.r.ext};
							dec.selectImm = 1'b1;
							dec.imm = {12'h000, inst.r.rSrc};
						end
						default: begin
							dec.op = noOpCode;
							dec.readRegB = inst.r.rDest;
						end
					endcase
				end
				`OP_MEM: begin
					dec.op = noOpCode;
					case (inst.r.ext)
						`EXT_LOAD: begin
							// rDest <= mem[rSrc], value comes back from memory
							dec.memAddr = inst.r.rSrc;
							dec.readRegA = inst.r.rSrc;
							dec.selectResult = 1'b1;
						end
						`EXT_STOR: begin
							// mem[rSrc] <= rDest, the OR rewrites rDest unchanged
							dec.memAddr = inst.r.rSrc;
							dec.readRegB = inst.r.rDest;
							dec.memWrite = 1'b1;
						end
						`EXT_JCOND: begin
							// no program counter here, jumps and branches do nothing
							dec.memAddr = inst.r.rDest;
							dec.readRegB = inst.r.rDest;
						end
						default: begin
							dec.readRegB = inst.r.rDest;
						end
					endcase
				end
				`OP_GSTOR: begin
					// glyph store has no glyph memory behind it
					dec.op = noOpCode;
					dec.memAddr = inst.r.rSrc;
					dec.readRegB = inst.r.rDest;
				end
				default: begin
					dec.op = noOpCode;
					dec.readRegB = inst.r.rDest;
				end
			endcase
		end else if (inst.r.prefix == 2'b11) begin
			// long form, full 16-bit load into the register named by bits 11:8
			dec.op = {`OP_LUI, inst.r.ext};
			dec.readRegB = inst.r.rDest;
			dec.selectImm = 1'b1;
			dec.imm = inst.l.imm16;
		end else begin
			dec.op = noOpCode;
			dec.readRegB = inst.r.rDest;
		end
	end

endmodule

// ==== logic/regFile.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module regFile (
	input logic clk,
	input logic reset,
	input logic [$clog2(`CPU_REG_COUNT)-1:0] readRegA,
	input logic [$clog2(`CPU_REG_COUNT)-1:0] readRegB,
	input logic [$clog2(`CPU_REG_COUNT)-1:0] memAddr,
	input logic [$clog2(`CPU_REG_COUNT)-1:0] dbgReg,
	output logic [`CPU_DATA_WIDTH-1:0] a,
	output logic [`CPU_DATA_WIDTH-1:0] b,
	output logic [`CPU_DATA_WIDTH-1:0] addrValue,
	output logic [`CPU_DATA_WIDTH-1:0] dbgData,
	input logic regWrite,
	input logic [$clog2(`CPU_REG_COUNT)-1:0] loadReg,
	input logic [`CPU_DATA_WIDTH-1:0] writeData
);

	logic [`CPU_DATA_WIDTH-1:0] regs [`CPU_REG_COUNT];

	// single write port
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `CPU_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (regWrite) begin
			regs[loadReg] <= writeData;
		end
	end

	// operands
	assign a = regs[readRegA];
	assign b = regs[readRegB];
	// register holding the data memory address
	assign addrValue = regs[memAddr];
	// testbench view
	assign dbgData = regs[dbgReg];

endmodule

// ==== logic/alu.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module alu (
	input logic clk,
	input logic reset,
	input logic flagUpdate,
	input cpuPkg::decoded_t dec,
	input logic [`CPU_DATA_WIDTH-1:0] a,
	input logic [`CPU_DATA_WIDTH-1:0] b,
	output logic [`CPU_DATA_WIDTH-1:0] result,
	output logic resultWrites,
	output cpuPkg::flags_t flags
);

	localparam int width = `CPU_DATA_WIDTH;
	localparam int shiftBits = $clog2(`CPU_DATA_WIDTH);

	logic [width-1:0] operandB;
	logic [shiftBits-1:0] shiftAmount;
	logic carryIn;
	logic [width:0] sum;    // top bit is carry out
	logic [width:0] diff;   // top bit is borrow
	logic addOverflow;
	logic subOverflow;
	cpuPkg::flags_t nextFlags;

	////////////////////////////////////////
	// operand and adder paths
	////////////////////////////////////////

	assign operandB = dec.selectImm ? dec.imm : b;
	assign shiftAmount = operandB[shiftBits-1:0];

	// only the carry forms feed c back in
	assign carryIn = flags.c & (dec.op == {`OP_RTYPE, `EXT_ADDC} ||
		dec.op == {`OP_RTYPE, `EXT_ADDCU} || dec.op == {`OP_ADDCI, 4'b0000} ||
		dec.op == {`OP_ADDCUI, 4'b0000});

	assign sum = {1'b0, a} + {1'b0, operandB} + {{width{1'b0}}, carryIn};
	assign diff = {1'b0, a} - {1'b0, operandB};

	// same-sign inputs with a flipped result sign
	assign addOverflow = (a[width-1] == operandB[width-1]) && (sum[width-1] != a[width-1]);
	// opposite-sign inputs and the sign of a is lost
	assign subOverflow = (a[width-1] != operandB[width-1]) && (diff[width-1] != a[width-1]);

	////////////////////////////////////////
	// result select
	////////////////////////////////////////

	always_comb begin
		result = '0;
		resultWrites = 1'b1;
		nextFlags = flags;
		case (dec.op[7:4])
			`OP_RTYPE: begin
				case (dec.op[3:0])
					`EXT_ADD, `EXT_ADDC: begin
						result = sum[width-1:0];
						nextFlags.f = addOverflow;
					end
					`EXT_ADDU, `EXT_ADDCU: begin
						result = sum[width-1:0];
						nextFlags.c = sum[width];
					end
					`EXT_SUB: begin
						result = diff[width-1:0];
						nextFlags.f = subOverflow;
						nextFlags.c = diff[width];
					end
					`EXT_CMP: begin
						resultWrites = 1'b0;
						nextFlags.z = a == operandB;
						nextFlags.l = a < operandB;
						nextFlags.n = $signed(a) < $signed(operandB);
					end
					`EXT_AND: result = a & operandB;
					`EXT_OR: result = a | operandB;
					`EXT_XOR: result = a ^ operandB;
					`EXT_NOT: result = ~operandB;
					`EXT_MOV: result = operandB;
					default: resultWrites = 1'b0;
				endcase
			end
			`OP_ADDI, `OP_ADDCI: begin
				result = sum[width-1:0];
				nextFlags.f = addOverflow;
			end
			`OP_ADDUI, `OP_ADDCUI: begin
				result = sum[width-1:0];
				nextFlags.c = sum[width];
			end
			`OP_SUBI: begin
				result = diff[width-1:0];
				nextFlags.f = subOverflow;
				nextFlags.c = diff[width];
			end
			`OP_CMPI, `OP_CMPUI: begin
				resultWrites = 1'b0;
				nextFlags.z = a == operandB;
				nextFlags.l = a < operandB;
				nextFlags.n = $signed(a) < $signed(operandB);
			end
			// MOVI, LUI and the long form all pass the immediate
			`OP_MOVI, `OP_LUI: result = operandB;
			`OP_SHIFT: begin
				case (dec.op[3:0])
					`EXT_LSH, `EXT_LSHI, `EXT_ALSH: result = a << shiftAmount;
					`EXT_RSH, `EXT_RSHI: result = a >> shiftAmount;
					`EXT_ARSH: result = $signed(a) >>> shiftAmount;
					default: resultWrites = 1'b0;
				endcase
			end
			default: resultWrites = 1'b0;
		endcase
	end

	// status register, only touched while executing
	always_ff @(posedge clk) begin
		if (reset) begin
			flags <= '0;
		end else if (flagUpdate) begin
			flags <= nextFlags;
		end
	end

endmodule

// ==== logic/dataMem.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module dataMem (
	input logic clk,
	input logic reset,
	input logic memWrite,
	input logic [$clog2(`CPU_MEM_DEPTH)-1:0] address,
	input logic [`CPU_DATA_WIDTH-1:0] writeData,
	output logic [`CPU_DATA_WIDTH-1:0] readData
);

	logic [`CPU_DATA_WIDTH-1:0] mem [`CPU_MEM_DEPTH];

	// unwritten words read back as zero
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `CPU_MEM_DEPTH; i++) begin
				mem[i] <= '0;
			end
			readData <= '0;
		end else begin
			if (memWrite) begin
				mem[address] <= writeData;
			end
			// registered read, old word on a same-edge write
			readData <= mem[address];
		end
	end

endmodule

// ==== logic/controller.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module controller (
	input logic clk,
	input logic reset,
	input logic instValid,
	input cpuPkg::instWord_t instIn,
	output logic instReady,
	output cpuPkg::instWord_t instReg,
	input cpuPkg::decoded_t dec,
	input logic [`CPU_DATA_WIDTH-1:0] aluResult,
	input logic resultWrites,
	input logic [`CPU_DATA_WIDTH-1:0] memData,
	output logic regWrite,
	output logic [`CPU_DATA_WIDTH-1:0] writeData,
	output logic memWrite,
	output logic flagUpdate
);

	typedef enum logic [1:0] {
		idle,
		execute,
		loadWait
	} state_t;

	state_t state;

	////////////////////////////////////////
	// sequencing
	////////////////////////////////////////

	// one instruction in flight, ready only while idle
	assign instReady = state == idle;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
		end else begin
			case (state)
				idle: if (instValid) state <= execute;
				// a load waits one more edge for the memory read
				execute: state <= dec.selectResult ? loadWait : idle;
				loadWait: state <= idle;
				default: state <= idle;
			endcase
		end
	end

	// capture on handshake
	always_ff @(posedge clk) begin
		if (instValid && instReady) begin
			instReg <= instIn;
		end
	end

	////////////////////////////////////////
	// write-back and memory strobes
	////////////////////////////////////////

	always_comb begin
		regWrite = 1'b0;
		writeData = aluResult;
		memWrite = 1'b0;
		flagUpdate = 1'b0;
		case (state)
			execute: begin
				// compares keep the register, loads write later
				regWrite = resultWrites & ~dec.selectResult;
				memWrite = dec.memWrite;
				flagUpdate = 1'b1;
			end
			loadWait: begin
				regWrite = 1'b1;
				writeData = memData;
			end
			default: begin
				regWrite = 1'b0;
			end
		endcase
	end

endmodule

// ==== logic/cpuCore.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpuCore (
	input logic clk,
	input logic reset,
	input logic instValid,
	input cpuPkg::instWord_t instIn,
	output logic instReady,
	input logic [$clog2(`CPU_REG_COUNT)-1:0] dbgReg,
	output logic [`CPU_DATA_WIDTH-1:0] dbgData,
	output cpuPkg::flags_t flags
);

	cpuPkg::instWord_t instReg;
	cpuPkg::decoded_t dec;
	logic [`CPU_DATA_WIDTH-1:0] a;
	logic [`CPU_DATA_WIDTH-1:0] b;
	logic [`CPU_DATA_WIDTH-1:0] addrValue;
	logic [`CPU_DATA_WIDTH-1:0] result;
	logic resultWrites;
	logic [`CPU_DATA_WIDTH-1:0] readData;
	logic regWrite;
	logic [`CPU_DATA_WIDTH-1:0] writeData;
	logic memWrite;
	logic flagUpdate;

	controller controller0 (
		.clk(clk), .reset(reset), .instValid(instValid), .instIn(instIn),
		.instReady(instReady), .instReg(instReg), .dec(dec), .aluResult(result),
		.resultWrites(resultWrites), .memData(readData), .regWrite(regWrite),
		.writeData(writeData), .memWrite(memWrite), .flagUpdate(flagUpdate)
	);

	decoder decoder0 (.inst(instReg), .dec(dec));

	regFile regFile0 (
		.clk(clk), .reset(reset), .readRegA(dec.readRegA), .readRegB(dec.readRegB),
		.memAddr(dec.memAddr), .dbgReg(dbgReg), .a(a), .b(b), .addrValue(addrValue),
		.dbgData(dbgData), .regWrite(regWrite), .loadReg(dec.loadReg), .writeData(writeData)
	);

	alu alu0 (
		.clk(clk), .reset(reset), .flagUpdate(flagUpdate), .dec(dec), .a(a), .b(b),
		.result(result), .resultWrites(resultWrites), .flags(flags)
	);

	// low byte of the address register picks the word, store data is operand a
	dataMem dataMem0 (
		.clk(clk), .reset(reset), .memWrite(memWrite),
		.address(addrValue[$clog2(`CPU_MEM_DEPTH)-1:0]), .writeData(a), .readData(readData)
	);

endmodule

// ==== test/cpuModel.svh ====
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

////////////////////////////////////////
// reference state
////////////////////////////////////////

logic [`CPU_DATA_WIDTH-1:0] modelRegs [`CPU_REG_COUNT];
logic [`CPU_DATA_WIDTH-1:0] modelMem [`CPU_MEM_DEPTH];
cpuPkg::flags_t modelFlags;
logic [31:0] lfsrState;

// galois lfsr, polynomial x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsrStep(input logic [31:0] state);
	if (state[0]) begin
		return (state >> 1) ^ 32'h8020_0003;
	end else begin
		return state >> 1;
	end
endfunction

// one lfsr step per bit, msb first
function automatic logic [15:0] randBits(input int count);
	logic [15:0] value;
	value = '0;
	for (int i = 0; i < count; i++) begin
		lfsrState = lfsrStep(lfsrState);
		value = {value[14:0], lfsrState[0]};
	end
	return value;
endfunction

function automatic logic [3:0] rand4();
	logic [15:0] value;
	value = randBits(4);
	return value[3:0];
endfunction

function automatic logic [7:0] rand8();
	logic [15:0] value;
	value = randBits(8);
	return value[7:0];
endfunction

task automatic modelReset();
	for (int i = 0; i < `CPU_REG_COUNT; i++) begin
		modelRegs[i] = '0;
	end
	for (int i = 0; i < `CPU_MEM_DEPTH; i++) begin
		modelMem[i] = '0;
	end
	modelFlags = '0;
endtask

////////////////////////////////////////
// operation rules
////////////////////////////////////////

// signed forms report overflow in f, unsigned forms the carry out in c
function automatic logic [15:0] addValues(input logic [15:0] x, input logic [15:0] y,
	input logic withCarry, input logic isSigned);
	logic [16:0] wide;
	wide = {1'b0, x} + {1'b0, y} + {16'h0000, withCarry & modelFlags.c};
	if (isSigned) begin
		modelFlags.f = (x[15] == y[15]) && (wide[15] != x[15]);
	end else begin
		modelFlags.c = wide[16];
	end
	return wide[15:0];
endfunction

// c is the borrow, set when x is below y unsigned
function automatic logic [15:0] subValues(input logic [15:0] x, input logic [15:0] y);
	logic [15:0] diff;
	diff = x - y;
	modelFlags.c = x < y;
	modelFlags.f = (x[15] != y[15]) && (diff[15] != x[15]);
	return diff;
endfunction

task automatic compareValues(input logic [15:0] x, input logic [15:0] y);
	modelFlags.z = x == y;
	modelFlags.l = x < y;
	modelFlags.n = $signed(x) < $signed(y);
endtask

task automatic modelExecute(input logic [`CPU_INST_WIDTH-1:0] word);
	logic [3:0] opc;
	logic [3:0] rd;
	logic [3:0] ext;
	logic [3:0] rs;
	logic [15:0] x;
	logic [15:0] y;
	logic [15:0] sImm;
	logic [15:0] uImm;
	opc = word[15:12];
	rd = word[11:8];
	ext = word[7:4];
	rs = word[3:0];
	x = modelRegs[rd];
	y = modelRegs[rs];
	sImm = {{8{word[7]}}, word[7:0]};
	uImm = {8'h00, word[7:0]};
	if (word[17:16] == 2'b11) begin
		// long form, the target register sits inside the value
		modelRegs[word[11:8]] = word[15:0];
	end else if (word[17:16] == 2'b00) begin
		case (opc)
			`OP_RTYPE: begin
				case (ext)
					`EXT_ADD: modelRegs[rd] = addValues(x, y, 1'b0, 1'b1);
					`EXT_ADDC: modelRegs[rd] = addValues(x, y, 1'b1, 1'b1);
					`EXT_ADDU: modelRegs[rd] = addValues(x, y, 1'b0, 1'b0);
					`EXT_ADDCU: modelRegs[rd] = addValues(x, y, 1'b1, 1'b0);
					`EXT_SUB: modelRegs[rd] = subValues(x, y);
					`EXT_CMP: compareValues(x, y);
					`EXT_AND: modelRegs[rd] = x & y;
					`EXT_OR: modelRegs[rd] = x | y;
					`EXT_XOR: modelRegs[rd] = x ^ y;
					`EXT_NOT: modelRegs[rd] = ~y;
					`EXT_MOV: modelRegs[rd] = y;
					default: ;
				endcase
			end
			`OP_ADDI: modelRegs[rd] = addValues(x, sImm, 1'b0, 1'b1);
			`OP_ADDCI: modelRegs[rd] = addValues(x, sImm, 1'b1, 1'b1);
			`OP_ADDUI: modelRegs[rd] = addValues(x, uImm, 1'b0, 1'b0);
			`OP_ADDCUI: modelRegs[rd] = addValues(x, uImm, 1'b1, 1'b0);
			`OP_SUBI: modelRegs[rd] = subValues(x, sImm);
			`OP_CMPI: compareValues(x, sImm);
			`OP_CMPUI: compareValues(x, uImm);
			`OP_MOVI: modelRegs[rd] = uImm;
			`OP_LUI: modelRegs[rd] = {word[7:0], 8'h00};
			`OP_SHIFT: begin
				case (ext)
					`EXT_LSH, `EXT_ALSH: modelRegs[rd] = x << y[3:0];
					`EXT_RSH: modelRegs[rd] = x >> y[3:0];
					`EXT_ARSH: modelRegs[rd] = $signed(x) >>> y[3:0];
					`EXT_LSHI: modelRegs[rd] = x << rs;
					`EXT_RSHI: modelRegs[rd] = x >> rs;
					default: ;
				endcase
			end
			`OP_MEM: begin
				// address is the low byte of rs
				if (ext == `EXT_LOAD) begin
					modelRegs[rd] = modelMem[y[7:0]];
				end else if (ext == `EXT_STOR) begin
					modelMem[y[7:0]] = x;
				end
			end
			default: ;
		endcase
	end
endtask

`endif

// ==== test/cpuTb.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpuTb;

	localparam int timeoutCycles = 20;

	// field choices for the random instruction stream
	localparam logic [3:0] arithExts [10] = '{`EXT_ADD, `EXT_ADDU, `EXT_ADDC, `EXT_ADDCU,
		`EXT_SUB, `EXT_AND, `EXT_OR, `EXT_XOR, `EXT_NOT, `EXT_MOV};
	localparam logic [3:0] immOps [5] = '{`OP_ADDI, `OP_ADDUI, `OP_ADDCI, `OP_ADDCUI, `OP_SUBI};
	localparam logic [3:0] shiftExts [6] = '{`EXT_LSH, `EXT_RSH, `EXT_ALSH, `EXT_ARSH,
		`EXT_LSHI, `EXT_RSHI};
	// primary codes and register-form codes with no operation behind them
	localparam logic [3:0] undefinedOps [3] = '{4'b0001, 4'b0010, 4'b0011};
	localparam logic [3:0] undefinedExts [5] = '{4'b0000, 4'b1000, 4'b1010, 4'b1100, 4'b1110};
	localparam logic [3:0] otherMemExts [4] = '{4'b0001, 4'b0010, 4'b1000, 4'b1110};

	logic clk;
	logic reset;
	logic instValid;
	cpuPkg::instWord_t instIn;
	logic instReady;
	logic [3:0] dbgReg;
	logic [`CPU_DATA_WIDTH-1:0] dbgData;
	cpuPkg::flags_t flags;

	logic hung;
	logic [`CPU_INST_WIDTH-1:0] lastInst;
	int errorCount;
	int checkCount;
	int testCount;

	`include "cpuModel.svh"

	cpuCore dut0 (
		.clk(clk), .reset(reset), .instValid(instValid), .instIn(instIn),
		.instReady(instReady), .dbgReg(dbgReg), .dbgData(dbgData), .flags(flags)
	);

	// 8 ns period
	always begin
		clk = 1'b0;
		#4;
		clk = 1'b1;
		#4;
	end

	////////////////////////////////////////
	// handshake and checks
	////////////////////////////////////////

	// polls on falling edges up to the timeout
	task automatic waitReady(input string phase);
		int waitCycles;
		waitCycles = 0;
		while (!instReady && waitCycles < timeoutCycles) begin
			@(negedge clk);
			waitCycles++;
		end
		if (!instReady) begin
			$display("instReady stayed low for %0d cycles %s instruction %h", timeoutCycles,
				phase, lastInst);
			hung = 1'b1;
		end
	endtask

	// driven on the falling edge and accepted at the rising edge in between
	task automatic sendInst(input logic [`CPU_INST_WIDTH-1:0] word);
		if (!hung) begin
			@(negedge clk);
			lastInst = word;
			waitReady("before accepting");
			if (!hung) begin
				instIn = word;
				instValid = 1'b1;
				@(negedge clk);
				instValid = 1'b0;
				// loads need one edge more than the rest
				waitReady("while executing");
				modelExecute(word);
			end
		end
	endtask

	// sampled a quarter period after the new dbgReg
	task automatic checkReg(input logic [3:0] r);
		if (!hung) begin
			@(negedge clk);
			dbgReg = r;
			#2;
			checkCount++;
			assert (dbgData === modelRegs[r]) else begin
				$display("FAIL %0t: r%0d reads %h, model has %h, after %h", $time, r, dbgData,
					modelRegs[r], lastInst);
				errorCount++;
			end
		end
	endtask

	// all sixteen registers and then the flags
	task automatic checkState();
		for (int r = 0; r < `CPU_REG_COUNT; r++) begin
			checkReg(4'(r));
		end
		if (!hung) begin
			checkCount++;
			assert (flags === modelFlags) else begin
				$display("FAIL %0t: flags cfzln %b, model has %b, after %h", $time, flags,
					modelFlags, lastInst);
				errorCount++;
			end
		end
	endtask

	task automatic runInst(input logic [`CPU_INST_WIDTH-1:0] word);
		sendInst(word);
		checkState();
	endtask

	task automatic endTest(input string name, input int errorsBefore, input int count);
		testCount++;
		$display("test %0d %s: %0d instructions, %0d errors", testCount, name, count,
			errorCount - errorsBefore);
	endtask

	////////////////////////////////////////
	// tests
	////////////////////////////////////////

	task automatic resetTest();
		int startErrors;
		startErrors = errorCount;
		@(negedge clk);
		checkCount++;
		assert (instReady === 1'b1) else begin
			$display("FAIL %0t: instReady is low after reset", $time);
			errorCount++;
		end
		checkState();
		endTest("reset state", startErrors, 0);
	endtask

	task automatic loadImmTest();
		int startErrors;
		startErrors = errorCount;
		// long form into every register through bits 11:8 of the value
		for (int r = 0; r < `CPU_REG_COUNT; r++) begin
			runInst({2'b11, rand4(), 4'(r), rand8()});
		end
		for (int i = 0; i < 8; i++) begin
			runInst({2'b00, `OP_MOVI, rand4(), rand8()});
			runInst({2'b00, `OP_LUI, rand4(), rand8()});
		end
		endTest("immediate loads", startErrors, 32);
	endtask

	task automatic arithTest();
		int startErrors;
		int pick;
		logic [`CPU_INST_WIDTH-1:0] word;
		startErrors = errorCount;
		for (int i = 0; i < 40; i++) begin
			// register or immediate form on one random bit
			if (randBits(1) != 16'h0) begin
				pick = int'(randBits(4)) % 10;
				word = {2'b00, `OP_RTYPE, rand4(), arithExts[pick], rand4()};
			end else begin
				pick = int'(randBits(3)) % 5;
				word = {2'b00, immOps[pick], rand4(), rand8()};
			end
			runInst(word);
		end
		endTest("arithmetic and logic", startErrors, 40);
	endtask

	task automatic shiftCompareTest();
		int startErrors;
		int pick;
		logic [3:0] rd;
		logic [`CPU_INST_WIDTH-1:0] word;
		startErrors = errorCount;
		for (int i = 0; i < 24; i++) begin
			pick = int'(randBits(3)) % 6;
			runInst({2'b00, `OP_SHIFT, rand4(), shiftExts[pick], rand4()});
		end
		for (int i = 0; i < 16; i++) begin
			rd = rand4();
			pick = int'(randBits(2)) % 3;
			// every fourth compare uses one register twice so that z gets set
			if (i % 4 == 0) begin
				word = {2'b00, `OP_RTYPE, rd, `EXT_CMP, rd};
			end else if (pick == 0) begin
				word = {2'b00, `OP_RTYPE, rd, `EXT_CMP, rand4()};
			end else if (pick == 1) begin
				word = {2'b00, `OP_CMPI, rd, rand8()};
			end else begin
				word = {2'b00, `OP_CMPUI, rd, rand8()};
			end
			runInst(word);
		end
		endTest("shifts and compares", startErrors, 40);
	endtask

	task automatic memoryTest();
		int startErrors;
		logic [3:0] addrReg;
		startErrors = errorCount;
		// store and load back through the same address register
		for (int i = 0; i < 12; i++) begin
			addrReg = rand4();
			runInst({2'b00, `OP_MEM, rand4(), `EXT_STOR, addrReg});
			runInst({2'b00, `OP_MEM, rand4(), `EXT_LOAD, addrReg});
		end
		// fresh addresses that were mostly never written
		for (int i = 0; i < 4; i++) begin
			addrReg = rand4();
			runInst({2'b00, `OP_MOVI, addrReg, rand8()});
			runInst({2'b00, `OP_MEM, rand4(), `EXT_LOAD, addrReg});
		end
		endTest("store and load", startErrors, 32);
	endtask

	function automatic logic [`CPU_INST_WIDTH-1:0] noOpWord();
		int kind;
		logic [`CPU_INST_WIDTH-1:0] word;
		kind = int'(randBits(3)) % 6;
		case (kind)
			0: begin
				// prefixes 01 and 10 are unused
				word = {2'b01, randBits(16)};
				if (randBits(1) != 16'h0) begin
					word[17:16] = 2'b10;
				end
			end
			// jumps and branches
			1: word = {2'b00, `OP_MEM, rand4(), `EXT_JCOND, rand4()};
			2: word = {2'b00, `OP_GSTOR, rand4(), rand4(), rand4()};
			3: word = {2'b00, undefinedOps[int'(randBits(2)) % 3], rand4(), rand8()};
			4: word = {2'b00, `OP_RTYPE, rand4(), undefinedExts[int'(randBits(3)) % 5], rand4()};
			default: word = {2'b00, `OP_MEM, rand4(), otherMemExts[int'(randBits(2))], rand4()};
		endcase
		return word;
	endfunction

	task automatic noOpTest();
		int startErrors;
		startErrors = errorCount;
		for (int i = 0; i < 24; i++) begin
			runInst(noOpWord());
		end
		endTest("no-op forms", startErrors, 24);
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial begin
		reset = 1'b1;
		instValid = 1'b0;
		instIn = '0;
		dbgReg = '0;
		hung = 1'b0;
		lastInst = '0;
		errorCount = 0;
		checkCount = 0;
		testCount = 0;
		lfsrState = 32'hc3ab_b450;
		modelReset();
		// reset over ten rising edges and released on a falling edge
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		resetTest();
		loadImmTest();
		arithTest();
		shiftCompareTest();
		memoryTest();
		noOpTest();
		$display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
		if (errorCount == 0 && !hung) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+logic
+incdir+test
logic/cpuPkg.sv
logic/decoder.sv
logic/regFile.sv
logic/alu.sv
logic/dataMem.sv
logic/controller.sv
logic/cpuCore.sv
test/cpuTb.sv

// ==== Makefile ====
TOP := cpuTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Result: PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
